/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f compile.f --top-module tb_uart_cmd_bridge -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* cmd_queue.sv */
`default_nettype none

module cmd_queue import uart_pkg::*; #(
  parameter int CMD_DEPTH = 4
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  cmd_vld,
  input  cmd_t cmd_in,
  input  wire  q_pop,
  output cmd_t q_cmd,
  output logic q_valid,
  output logic cmd_credit
);

  localparam int PTR_W = $clog2(CMD_DEPTH);

  cmd_t             mem [CMD_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_pop;

  // host holds credits, so a push never finds the queue full
  assign do_pop  = q_pop && q_valid;
  assign q_valid = (count != '0);
  assign q_cmd   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (cmd_vld) begin
      mem[wr_ptr] <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (cmd_vld) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count      <= count + (PTR_W+1)'(cmd_vld) - (PTR_W+1)'(do_pop);
      // one credit back per freed entry
      cmd_credit <= do_pop;
    end
  end

endmodule

`default_nettype wire

/* cmd_sequencer.sv */
`default_nettype none

module cmd_sequencer import uart_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,
  input  cmd_t     q_cmd,
  input  wire      q_valid,
  output logic     q_pop,
  output byte_t    tx_byte,
  output logic     tx_start,
  input  wire      tx_busy,
  input  wire      rx_valid,
  input  rd_resp_t rx_resp,
  output logic     read_vld,
  output rd_resp_t read_resp
);

  seq_state_t state;
  cmd_t       cmd_r;
  logic       tx_busy_d;
  logic       tx_done;

  // first idle cycle after a frame
  assign tx_done = tx_busy_d && !tx_busy;

  always_ff @(posedge clk) begin
    if (state == seq_idle && q_valid) begin
      cmd_r <= q_cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy_d <= 1'b0;
    end else begin
      tx_busy_d <= tx_busy;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= seq_idle;
      q_pop    <= 1'b0;
      tx_start <= 1'b0;
      read_vld <= 1'b0;
    end else begin
      q_pop    <= 1'b0;
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      case (state)
        seq_idle: begin
          // a frame just requested has not raised tx_busy yet
          if (q_valid && !tx_busy && !tx_start) begin
            q_pop <= 1'b1;
            state <= seq_send_addr;
          end
        end
        seq_send_addr: begin
          tx_start <= 1'b1;
          tx_byte  <= {cmd_r.rw, cmd_r.addr};
          state    <= cmd_r.rw ? seq_wait_resp : seq_send_data;
        end
        seq_send_data: begin
          if (tx_done) begin
            tx_start <= 1'b1;
            tx_byte  <= cmd_r.data;
            state    <= seq_idle;
          end
        end
        default: begin
          // only a frame received here belongs to the read
          if (rx_valid) begin
            read_vld  <= 1'b1;
            read_resp <= rx_resp;
            state     <= seq_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* compile.f */
uart_pkg.sv
cmd_queue.sv
uart_tx_framer.sv
uart_rx_deframer.sv
cmd_sequencer.sv
uart_cmd_bridge.sv
tb_clock_gen.sv
tb_uart_cmd_bridge.sv

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_uart_cmd_bridge.sv */
`default_nettype none

module tb_uart_cmd_bridge
  import uart_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CPB        = 8;
  localparam int DEPTH      = 4;
  localparam int NUM_CMDS   = 200;
  localparam int WAIT_LIMIT = 5000;

  logic     clk;
  logic     rst_n;
  logic     cmd_vld;
  cmd_t     cmd_in;
  logic     cmd_credit;
  logic     rx;
  logic     tx;
  logic     read_vld;
  rd_resp_t read_resp;

  logic [31:0] lfsr = 32'he893f8ef;
  int          credits = DEPTH;
  int          credit_pulses = 0;
  int          sent = 0;
  int          reads_total = 0;
  int          reads_checked = 0;
  cmd_t        exp_cmd [$];
  rd_resp_t    exp_resp [$];
  byte_t       regs [128];

  tb_clock_gen #(.RESET_CYCLES(4)) u_clock_gen (.clk(clk), .rst_n(rst_n));

  uart_cmd_bridge #(
    .CLKS_PER_BIT (CPB),
    .CMD_DEPTH    (DEPTH),
    .PARITY_CHECK (1'b1)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_in     (cmd_in),
    .cmd_credit (cmd_credit),
    .rx         (rx),
    .tx         (tx),
    .read_vld   (read_vld),
    .read_resp  (read_resp)
  );

  task automatic stop_fail(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic send_cmd(input cmd_t c);
    int t;
    t = 0;
    while (credits == 0) begin
      @(posedge clk);
      #1;
      t++;
      if (t > WAIT_LIMIT) stop_fail("timeout: no command credit came back");
    end
    cmd_in  = c;
    cmd_vld = 1'b1;
    credits--;
    sent++;
    exp_cmd.push_back(c);
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  // decode one tx frame at bit centers
  task automatic recv_frame(output byte_t b);
    logic [10:0] f;
    int          t;
    t = 0;
    while (tx !== 1'b0) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) stop_fail("timeout: no start bit seen on tx");
    end
    repeat (CPB / 2) @(negedge clk);
    f[0] = tx;
    for (int i = 1; i < 11; i++) begin
      repeat (CPB) @(negedge clk);
      f[i] = tx;
    end
    assert (f[0] == 1'b0 && f[10] == 1'b1 && (^f[9:1]) == 1'b1) else
      stop_fail($sformatf("Fail %0t: bad tx frame %b (start, stop or parity)", $time, f));
    b = f[8:1];
  endtask

  task automatic send_frame(input byte_t b, input logic bad_par);
    logic [10:0] f;
    f = {1'b1, ~(^b) ^ bad_par, b, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < 11; i++) begin
      rx = f[i];
      repeat (CPB) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic host_drive();
    logic [31:0] r;
    cmd_t        c;
    int          gap;
    for (int n = 0; n < NUM_CMDS; n++) begin
      r = rand_bits(16);
      c = r[15:0];
      r = rand_bits(2);
      gap = 0;
      // zero gap often enough to drain all credits
      if (r[1:0] != 2'd0) begin
        r = rand_bits(4);
        gap = int'(r[3:0]);
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      send_cmd(c);
    end
  endtask

  // remote register device
  task automatic device_model();
    cmd_t        c;
    byte_t       b;
    rd_resp_t    e;
    logic [31:0] r;
    int          t;
    for (int n = 0; n < NUM_CMDS; n++) begin
      t = 0;
      while (exp_cmd.size() == 0) begin
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) stop_fail("timeout: host sent no further command");
      end
      c = exp_cmd.pop_front();
      recv_frame(b);
      assert (b == {c.rw, c.addr}) else
        stop_fail($sformatf("Fail %0t: tx byte %h, expected flag and address %h",
                            $time, b, {c.rw, c.addr}));
      if (!c.rw) begin
        recv_frame(b);
        assert (b == c.data) else
          stop_fail($sformatf("Fail %0t: tx data %h, expected %h", $time, b, c.data));
        regs[c.addr] = b;
      end else begin
        r = rand_bits(4);
        repeat (int'(r[3:0]) * CPB) @(posedge clk);
        r = rand_bits(2);
        e.data       = regs[c.addr];
        e.parity_err = (r[1:0] == 2'd0);
        exp_resp.push_back(e);
        reads_total++;
        send_frame(e.data, e.parity_err);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && cmd_credit) begin
      credits++;
      credit_pulses++;
      assert (credit_pulses <= sent && credits <= DEPTH) else
        stop_fail($sformatf("Fail %0t: %0d credits back for %0d commands", $time,
                            credit_pulses, sent));
    end
    if (rst_n && read_vld) begin
      assert (exp_resp.size() > 0) else stop_fail("read response with no read outstanding");
      assert (read_resp == exp_resp[0]) else
        stop_fail($sformatf("Fail %0t: read %h err %b, expected %h err %b", $time,
                            read_resp.data, read_resp.parity_err,
                            exp_resp[0].data, exp_resp[0].parity_err));
      void'(exp_resp.pop_front());
      reads_checked++;
    end
  end

  initial begin
    int t;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    rx      = 1'b1;
    for (int i = 0; i < 128; i++) regs[i] = '0;
    t = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) stop_fail("timeout: reset never released");
    end
    repeat (4) begin
      @(negedge clk);
      assert (tx === 1'b1 && read_vld === 1'b0 && cmd_credit === 1'b0)
        else stop_fail($sformatf("Fail %0t: outputs not idle after reset", $time));
    end
    @(posedge clk);
    #1;
    fork
      host_drive();
      device_model();
    join
    t = 0;
    while (reads_checked < reads_total) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) stop_fail("timeout: read response never reached the host");
    end
    if (credits == DEPTH) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_fail("command credits not all returned at end of run");
    end
  end

endmodule

`default_nettype wire

/* uart_cmd_bridge.sv */
`default_nettype none

module uart_cmd_bridge import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 8,
  parameter int CMD_DEPTH    = 4,
  parameter bit PARITY_CHECK = 1'b1
) (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      cmd_vld,
  input  cmd_t     cmd_in,
  output logic     cmd_credit,
  input  wire      rx,
  output logic     tx,
  output logic     read_vld,
  output rd_resp_t read_resp
);

  cmd_t     q_cmd;
  logic     q_valid;
  logic     q_pop;
  byte_t    tx_byte;
  logic     tx_start;
  logic     tx_busy;
  logic     rx_valid;
  rd_resp_t rx_resp;

  cmd_queue #(
    .CMD_DEPTH (CMD_DEPTH)
  ) u_cmd_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_in     (cmd_in),
    .q_pop      (q_pop),
    .q_cmd      (q_cmd),
    .q_valid    (q_valid),
    .cmd_credit (cmd_credit)
  );

  cmd_sequencer u_cmd_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .q_cmd     (q_cmd),
    .q_valid   (q_valid),
    .q_pop     (q_pop),
    .tx_byte   (tx_byte),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .rx_valid  (rx_valid),
    .rx_resp   (rx_resp),
    .read_vld  (read_vld),
    .read_resp (read_resp)
  );

  uart_tx_framer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx_framer (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx_deframer #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_CHECK (PARITY_CHECK)
  ) u_uart_rx_deframer (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_resp  (rx_resp)
  );

endmodule

`default_nettype wire

/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // payload byte on the serial line
  typedef logic [7:0] byte_t;

  // register address inside the remote device
  typedef logic [6:0] addr_t;

  typedef struct packed {
    logic  rw;
    addr_t addr;
    byte_t data;
  } cmd_t;

  typedef struct packed {
    byte_t data;
    logic  parity_err;
  } rd_resp_t;

  typedef enum logic [1:0] {
    seq_idle,
    seq_send_addr,
    seq_send_data,
    seq_wait_resp
  } seq_state_t;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_t;

endpackage

`default_nettype wire

/* uart_rx_deframer.sv */
`default_nettype none

module uart_rx_deframer import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 8,
  parameter bit PARITY_CHECK = 1'b1
) (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      rx,
  output logic     rx_valid,
  output rd_resp_t rx_resp
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  byte_t            data_sh;
  logic             par_bit;
  logic             half_end;
  logic             bit_end;
  logic             bad_parity;

  assign half_end   = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
  assign bit_end    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  // nine bits must hold an odd number of ones
  assign bad_parity = PARITY_CHECK && !(^{par_bit, data_sh});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rx_idle;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        rx_idle: begin
          clk_cnt <= '0;
          if (rx_prev && !rx_sync) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (half_end) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // glitch shorter than half a bit is ignored
            state   <= rx_sync ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (bit_end) begin
            clk_cnt <= '0;
            data_sh <= {rx_sync, data_sh[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= rx_parity;
            end
          end
        end
        rx_parity: begin
          if (bit_end) begin
            clk_cnt <= '0;
            par_bit <= rx_sync;
            state   <= rx_stop;
          end
        end
        default: begin
          if (bit_end) begin
            rx_valid           <= 1'b1;
            rx_resp.data       <= data_sh;
            rx_resp.parity_err <= bad_parity || !rx_sync;
            state              <= rx_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* uart_tx_framer.sv */
`default_nettype none

module uart_tx_framer import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   tx_start,
  input  byte_t tx_byte,
  output logic  tx_busy,
  output logic  tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  logic [10:0]      sh_reg;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic             bit_end;

  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // line follows the low end of the shift register
  assign tx = sh_reg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sh_reg  <= '1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx_busy <= 1'b0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // stop, odd parity, data lsb first, start
        sh_reg  <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
        clk_cnt <= '0;
        bit_cnt <= '0;
        tx_busy <= 1'b1;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      sh_reg  <= {1'b1, sh_reg[10:1]};
      if (bit_cnt == 4'd10) begin
        tx_busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire
